//--- hdl/exec_defs.svh
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// ========================================
// Datapath widths
// ========================================

// Data and address width
`define EXEC_XLEN 32

// Shift amount taken from the low bits of src1
`define EXEC_SHAMT_W 5

// Destination register index, 32 GPRs
`define EXEC_RD_W 5

// ========================================
// Fixed shifts
// ========================================

// LU12I style immediate placement
`define EXEC_LUI_SHIFT 12

`endif

//--- hdl/exec_pkg.sv
`default_nettype none

package exec_pkg;

  // ========================================
  // Operation class
  // ========================================

  // Picks which unit's result is written back
  typedef enum logic {
    CLASS_ALU = 1'b0,
    CLASS_BR  = 1'b1
  } exec_class_e;

  // ========================================
  // ALU operations
  // ========================================

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    // Signedness from signed_sel
    ALU_SLT = 4'd2,
    ALU_AND = 4'd3,
    ALU_OR  = 4'd4,
    ALU_XOR = 4'd5,
    ALU_NOR = 4'd6,
    ALU_SL  = 4'd7,
    // Arithmetic when signed_sel is set
    ALU_SR  = 4'd8,
    ALU_LUI = 4'd9
  } alu_op_e;

  // Branch operations
  typedef enum logic [2:0] {
    BR_BEQ  = 3'd0,
    BR_BNE  = 3'd1,
    BR_BLT  = 3'd2,
    BR_BGE  = 3'd3,
    // Unconditional, both write the link address
    BR_JIRL = 3'd4,
    BR_BL   = 3'd5
  } br_op_e;

endpackage : exec_pkg

`default_nettype wire

//--- hdl/exec_op_if.sv
`default_nettype none

`include "exec_defs.svh"

// Issued operation and its operands
interface exec_op_if
  import exec_pkg::*;
();

  logic                   valid;
  exec_class_e            op_class;
  alu_op_e                alu_op;
  br_op_e                 br_op;
  logic                   signed_sel;
  logic [`EXEC_XLEN-1:0]  src0;
  logic [`EXEC_XLEN-1:0]  src1;
  logic [`EXEC_XLEN-1:0]  pc;
  logic [`EXEC_XLEN-1:0]  imm;
  logic [`EXEC_RD_W-1:0]  rd;

  // Producer side, drives everything
  modport issue (
    output valid, op_class, alu_op, br_op, signed_sel,
    output src0, src1, pc, imm, rd
  );

  // Functional units, operands only
  modport fu (
    input src0, src1, signed_sel, alu_op, br_op, pc, imm
  );

  // Writeback, control needed for result select
  modport wb (
    input valid, op_class, br_op, rd
  );

endinterface : exec_op_if

`default_nettype wire

//--- hdl/alu.sv
`default_nettype none

`include "exec_defs.svh"

module alu
  import exec_pkg::*;
(
  exec_op_if.fu                 ops_i,
  output logic [`EXEC_XLEN-1:0] res_o
);

  // ========================================
  // Operand prep
  // ========================================

  // Only the low bits of src1 shift
  logic [`EXEC_SHAMT_W-1:0] shamt;
  // Compare result, signed or unsigned
  logic                     less;
  // Right shift, fill chosen by signed_sel
  logic [`EXEC_XLEN-1:0]    shr_res;

  assign shamt = ops_i.src1[`EXEC_SHAMT_W-1:0];

  always_comb begin
    if (ops_i.signed_sel) begin
      less = $signed(ops_i.src0) < $signed(ops_i.src1);
    end else begin
      less = ops_i.src0 < ops_i.src1;
    end
  end

  always_comb begin
    if (ops_i.signed_sel) begin
      // Sign bit fills from the left
      shr_res = $unsigned($signed(ops_i.src0) >>> shamt);
    end else begin
      shr_res = ops_i.src0 >> shamt;
    end
  end

  // ========================================
  // Result select
  // ========================================

  always_comb begin
    case (ops_i.alu_op)
      ALU_ADD: begin
        res_o = ops_i.src0 + ops_i.src1;
      end
      ALU_SUB: begin
        res_o = ops_i.src0 - ops_i.src1;
      end
      ALU_SLT: begin
        // Zero extended flag
        res_o = {{(`EXEC_XLEN-1){1'b0}}, less};
      end
      ALU_AND: begin
        res_o = ops_i.src0 & ops_i.src1;
      end
      ALU_OR: begin
        res_o = ops_i.src0 | ops_i.src1;
      end
      ALU_XOR: begin
        res_o = ops_i.src0 ^ ops_i.src1;
      end
      ALU_NOR: begin
        res_o = ~(ops_i.src0 | ops_i.src1);
      end
      ALU_SL: begin
        res_o = ops_i.src0 << shamt;
      end
      ALU_SR: begin
        res_o = shr_res;
      end
      ALU_LUI: begin
        // Immediate arrives on src1
        res_o = ops_i.src1 << `EXEC_LUI_SHIFT;
      end
      default: begin
        res_o = '0;
      end
    endcase
  end

endmodule : alu

`default_nettype wire

//--- hdl/branch_unit.sv
`default_nettype none

`include "exec_defs.svh"

module branch_unit
  import exec_pkg::*;
(
  exec_op_if.fu                 ops_i,
  output logic                  taken_o,
  output logic [`EXEC_XLEN-1:0] target_o,
  output logic [`EXEC_XLEN-1:0] link_o
);

  // ========================================
  // Condition
  // ========================================

  logic                  eq;
  logic                  lt;
  // Base of the target address
  logic [`EXEC_XLEN-1:0] base;

  assign eq = ops_i.src0 == ops_i.src1;

  // blt and bge share this compare
  always_comb begin
    if (ops_i.signed_sel) begin
      lt = $signed(ops_i.src0) < $signed(ops_i.src1);
    end else begin
      lt = ops_i.src0 < ops_i.src1;
    end
  end

  always_comb begin
    case (ops_i.br_op)
      BR_BEQ:  taken_o = eq;
      BR_BNE:  taken_o = ~eq;
      BR_BLT:  taken_o = lt;
      BR_BGE:  taken_o = ~lt;
      // Jumps always go
      BR_JIRL: taken_o = 1'b1;
      BR_BL:   taken_o = 1'b1;
      default: taken_o = 1'b0;
    endcase
  end

  // ========================================
  // Target and link
  // ========================================

  // Register indirect for jirl, pc relative otherwise
  assign base = (ops_i.br_op == BR_JIRL) ? ops_i.src0 : ops_i.pc;

  assign target_o = base + ops_i.imm;

  // Return address, next sequential instruction
  assign link_o = ops_i.pc + `EXEC_XLEN'd4;

endmodule : branch_unit

`default_nettype wire

//--- hdl/exec_writeback.sv
`default_nettype none

`include "exec_defs.svh"

module exec_writeback
  import exec_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  exec_op_if.wb                 ops_i,
  input  logic [`EXEC_XLEN-1:0] alu_res_i,
  input  logic                  br_taken_i,
  input  logic [`EXEC_XLEN-1:0] br_target_i,
  input  logic [`EXEC_XLEN-1:0] br_link_i,
  output logic                  wb_valid_o,
  output logic                  wb_we_o,
  output logic [`EXEC_RD_W-1:0] wb_rd_o,
  output logic [`EXEC_XLEN-1:0] wb_data_o,
  output logic                  redirect_o,
  output logic [`EXEC_XLEN-1:0] redirect_pc_o
);

  // ========================================
  // Next state
  // ========================================

  logic                  is_alu;
  // jirl or bl, writes the return address
  logic                  is_link;
  logic                  we_d;
  logic [`EXEC_XLEN-1:0] data_d;
  logic                  redir_d;

  assign is_alu  = ops_i.op_class == CLASS_ALU;
  assign is_link = (ops_i.op_class == CLASS_BR) &&
                   ((ops_i.br_op == BR_JIRL) || (ops_i.br_op == BR_BL));

  // r0 is hard-wired zero, never written
  assign we_d = ops_i.valid && (is_alu || is_link) && (ops_i.rd != '0);

  // Conditional branches carry no data
  assign data_d = is_alu  ? alu_res_i :
                  is_link ? br_link_i : '0;

  assign redir_d = ops_i.valid && (ops_i.op_class == CLASS_BR) && br_taken_i;

  // ========================================
  // Output registers
  // ========================================

  // One cycle latency, new op every clock
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_valid_o    <= 1'b0;
      wb_we_o       <= 1'b0;
      wb_rd_o       <= '0;
      wb_data_o     <= '0;
      redirect_o    <= 1'b0;
      redirect_pc_o <= '0;
    end else begin
      wb_valid_o    <= ops_i.valid;
      wb_we_o       <= we_d;
      wb_rd_o       <= ops_i.rd;
      wb_data_o     <= data_d;
      redirect_o    <= redir_d;
      // Target only meaningful with redirect
      redirect_pc_o <= redir_d ? br_target_i : '0;
    end
  end

endmodule : exec_writeback

`default_nettype wire

//--- hdl/exec_stage.sv
`default_nettype none

`include "exec_defs.svh"

module exec_stage
  import exec_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Issued operation
  input  logic                  valid_i,
  input  exec_class_e           op_class_i,
  input  alu_op_e               alu_op_i,
  input  br_op_e                br_op_i,
  input  logic                  signed_i,
  input  logic [`EXEC_XLEN-1:0] src0_i,
  input  logic [`EXEC_XLEN-1:0] src1_i,
  input  logic [`EXEC_XLEN-1:0] pc_i,
  input  logic [`EXEC_XLEN-1:0] imm_i,
  input  logic [`EXEC_RD_W-1:0] rd_i,
  // Registered writeback and redirect
  output logic                  wb_valid_o,
  output logic                  wb_we_o,
  output logic [`EXEC_RD_W-1:0] wb_rd_o,
  output logic [`EXEC_XLEN-1:0] wb_data_o,
  output logic                  redirect_o,
  output logic [`EXEC_XLEN-1:0] redirect_pc_o
);

  // ========================================
  // Issue bundle
  // ========================================

  exec_op_if ops ();

  // Top ports drive the issue side
  assign ops.valid      = valid_i;
  assign ops.op_class   = op_class_i;
  assign ops.alu_op     = alu_op_i;
  assign ops.br_op      = br_op_i;
  assign ops.signed_sel = signed_i;
  assign ops.src0       = src0_i;
  assign ops.src1       = src1_i;
  assign ops.pc         = pc_i;
  assign ops.imm        = imm_i;
  assign ops.rd         = rd_i;

  // Unit results
  logic [`EXEC_XLEN-1:0] alu_res;
  logic                  br_taken;
  logic [`EXEC_XLEN-1:0] br_target;
  logic [`EXEC_XLEN-1:0] br_link;

  // ========================================
  // Units
  // ========================================

  // Both units see the same operands in parallel
  alu u_alu (
    .ops_i (ops.fu),
    .res_o (alu_res)
  );

  branch_unit u_branch (
    .ops_i    (ops.fu),
    .taken_o  (br_taken),
    .target_o (br_target),
    .link_o   (br_link)
  );

  exec_writeback u_wb (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .ops_i         (ops.wb),
    .alu_res_i     (alu_res),
    .br_taken_i    (br_taken),
    .br_target_i   (br_target),
    .br_link_i     (br_link),
    .wb_valid_o    (wb_valid_o),
    .wb_we_o       (wb_we_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

endmodule : exec_stage

`default_nettype wire

//--- test/exec_stage_tb.sv
`default_nettype none

`include "exec_defs.svh"

module exec_stage_tb
  import exec_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_TESTS = 64;

  logic                  clk_i;
  logic                  arst_n_i;
  logic                  valid_i;
  exec_class_e           op_class_i;
  alu_op_e               alu_op_i;
  br_op_e                br_op_i;
  logic                  signed_i;
  logic [`EXEC_XLEN-1:0] src0_i;
  logic [`EXEC_XLEN-1:0] src1_i;
  logic [`EXEC_XLEN-1:0] pc_i;
  logic [`EXEC_XLEN-1:0] imm_i;
  logic [`EXEC_RD_W-1:0] rd_i;
  logic                  wb_valid_o;
  logic                  wb_we_o;
  logic [`EXEC_RD_W-1:0] wb_rd_o;
  logic [`EXEC_XLEN-1:0] wb_data_o;
  logic                  redirect_o;
  logic [`EXEC_XLEN-1:0] redirect_pc_o;

  // Vector table with one entry per data line
  string       t_name [MAX_TESTS];
  logic [31:0] t_cls [MAX_TESTS];
  logic [31:0] t_aop [MAX_TESTS];
  logic [31:0] t_bop [MAX_TESTS];
  logic [31:0] t_sgn [MAX_TESTS];
  logic [31:0] t_src0 [MAX_TESTS];
  logic [31:0] t_src1 [MAX_TESTS];
  logic [31:0] t_pc [MAX_TESTS];
  logic [31:0] t_imm [MAX_TESTS];
  logic [31:0] t_rd [MAX_TESTS];
  logic [31:0] t_we [MAX_TESTS];
  logic [31:0] t_data [MAX_TESTS];
  logic [31:0] t_redir [MAX_TESTS];
  logic [31:0] t_rpc [MAX_TESTS];
  bit          t_bubble [MAX_TESTS];

  int          n_tests = 0;
  int          errors = 0;
  int          ok_cnt = 0;
  int          bad_cnt = 0;
  bit          loaded = 1'b0;
  bit          cur_ok;
  logic [31:0] rng = 32'h4959_35d0;

  exec_stage uut (
    .clk_i, .arst_n_i, .valid_i, .op_class_i, .alu_op_i, .br_op_i, .signed_i,
    .src0_i, .src1_i, .pc_i, .imm_i, .rd_i, .wb_valid_o, .wb_we_o, .wb_rd_o,
    .wb_data_o, .redirect_o, .redirect_pc_o
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ========================================
  // Helpers
  // ========================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Reference results for the random logic and arithmetic lines
  function automatic logic [31:0] expect_alu(input logic [3:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
    case (alu_op_e'(op))
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_NOR: return ~(a | b);
      default: return 32'h0;
    endcase
  endfunction

  task automatic load_tests();
    int    fd;
    int    cnt;
    string line;
    string nm;
    fd = $fopen("test/exec_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/exec_tests.txt");
      errors++;
    end else begin
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
        line = "";
        cnt = $fgets(line, fd);
        // Skip comments and blank lines
        if (cnt > 1 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", nm,
                        t_cls[n_tests], t_aop[n_tests], t_bop[n_tests], t_sgn[n_tests],
                        t_src0[n_tests], t_src1[n_tests], t_pc[n_tests], t_imm[n_tests],
                        t_rd[n_tests], t_we[n_tests], t_data[n_tests], t_redir[n_tests],
                        t_rpc[n_tests]);
          if (cnt != 14) begin
            $display("Malformed line in test file: %s", line);
            errors++;
          end else begin
            t_name[n_tests] = nm;
            t_bubble[n_tests] = (nm.len() >= 6) && (nm.substr(0, 5) == "bubble");
            // Random operands get their expected data here
            if (nm.len() >= 4 && nm.substr(0, 3) == "rand") begin
              rng = xorshift32(rng);
              t_src0[n_tests] = rng;
              rng = xorshift32(rng);
              t_src1[n_tests] = rng;
              t_data[n_tests] = expect_alu(t_aop[n_tests][3:0], t_src0[n_tests],
                                           t_src1[n_tests]);
              t_we[n_tests] = 32'(t_rd[n_tests][4:0] != 5'd0);
            end
            n_tests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_op(input int k);
    valid_i    = !t_bubble[k];
    op_class_i = exec_class_e'(t_cls[k][0]);
    alu_op_i   = alu_op_e'(t_aop[k][3:0]);
    br_op_i    = br_op_e'(t_bop[k][2:0]);
    signed_i   = t_sgn[k][0];
    src0_i     = t_src0[k];
    src1_i     = t_src1[k];
    pc_i       = t_pc[k];
    imm_i      = t_imm[k];
    rd_i       = t_rd[k][4:0];
  endtask

  task automatic check_field(input string test, input string field, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s %s expected %h actual %h", test, field, exp, act);
      cur_ok = 1'b0;
    end
  endtask

  task automatic finish_test(input string test);
    if (cur_ok) begin
      ok_cnt++;
      $display("%-14s ok", test);
    end else begin
      bad_cnt++;
      errors++;
      $display("%-14s mismatch", test);
    end
  endtask

  // Outputs of line k one cycle after it was sampled
  task automatic check_result(input int k);
    cur_ok = 1'b1;
    check_field(t_name[k], "wb_valid", 32'(!t_bubble[k]), 32'(wb_valid_o));
    check_field(t_name[k], "wb_we", t_we[k], 32'(wb_we_o));
    check_field(t_name[k], "redirect", t_redir[k], 32'(redirect_o));
    if (!t_bubble[k]) begin
      check_field(t_name[k], "wb_rd", t_rd[k], 32'(wb_rd_o));
    end
    if (t_we[k][0]) begin
      check_field(t_name[k], "wb_data", t_data[k], wb_data_o);
    end
    if (t_redir[k][0]) begin
      check_field(t_name[k], "redirect_pc", t_rpc[k], redirect_pc_o);
    end
    finish_test(t_name[k]);
  endtask

  // ========================================
  // Main sequence
  // ========================================

  initial begin
    arst_n_i = 1'b0;
    valid_i = 1'b0;
    op_class_i = CLASS_ALU;
    alu_op_i = ALU_ADD;
    br_op_i = BR_BEQ;
    signed_i = 1'b0;
    src0_i = '0;
    src1_i = '0;
    pc_i = '0;
    imm_i = '0;
    rd_i = '0;
    load_tests();
    loaded = 1'b1;
    repeat (8) @(posedge clk_i);
    #2 cur_ok = 1'b1;
    // Reset values, still untouched by any sampled input
    check_field("reset_values", "wb_valid", 32'h0, 32'(wb_valid_o));
    check_field("reset_values", "wb_we", 32'h0, 32'(wb_we_o));
    check_field("reset_values", "redirect", 32'h0, 32'(redirect_o));
    check_field("reset_values", "wb_rd", 32'h0, 32'(wb_rd_o));
    check_field("reset_values", "wb_data", 32'h0, wb_data_o);
    check_field("reset_values", "redirect_pc", 32'h0, redirect_pc_o);
    finish_test("reset_values");
    arst_n_i = 1'b1;
    // Idle stage after reset with valid held low
    repeat (2) @(posedge clk_i);
    #2 cur_ok = 1'b1;
    check_field("reset_idle", "wb_valid", 32'h0, 32'(wb_valid_o));
    check_field("reset_idle", "wb_we", 32'h0, 32'(wb_we_o));
    check_field("reset_idle", "redirect", 32'h0, 32'(redirect_o));
    finish_test("reset_idle");
    // One op per cycle with the previous op checked as the next is driven
    for (int i = 0; i < n_tests; i++) begin
      @(posedge clk_i);
      #2;
      if (i > 0) begin
        check_result(i - 1);
      end
      drive_op(i);
    end
    @(posedge clk_i);
    #2;
    if (n_tests > 0) begin
      check_result(n_tests - 1);
    end
    $display("Tests: %0d ok, %0d with errors, %0d errors in all", ok_cnt, bad_cnt, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog scaled by the number of vectors
  initial begin
    wait (loaded);
    #((n_tests + 20) * 20);
    $display("Timeout: the test sequence did not finish in time");
    $display("Verification failed");
    $finish;
  end

endmodule : exec_stage_tb

`default_nettype wire

//--- test/exec_tests.txt
# name class aluop brop signed src0 src1 pc imm rd | exp_we exp_data exp_redir exp_rpc (hex)
# rand* lines get xorshift operands and computed data; bubble* lines drive valid low
add_wrap     0 0 0 0 ffffffff 00000002 00000000 00000000 01 1 00000001 0 00000000
sub_wrap     0 1 0 0 00000000 00000001 00000000 00000000 02 1 ffffffff 0 00000000
and_basic    0 3 0 0 f0f0f0f0 ff00ff00 00000000 00000000 03 1 f000f000 0 00000000
or_basic     0 4 0 0 f0f0f0f0 0f0f0000 00000000 00000000 04 1 fffff0f0 0 00000000
xor_basic    0 5 0 0 aaaaaaaa ffff0000 00000000 00000000 05 1 5555aaaa 0 00000000
nor_basic    0 6 0 0 12340000 00005678 00000000 00000000 06 1 edcba987 0 00000000
lui_imm      0 9 0 0 00000000 00012345 00000000 00000000 07 1 12345000 0 00000000
slt_signed   0 2 0 1 ffffffff 00000001 00000000 00000000 08 1 00000001 0 00000000
slt_unsigned 0 2 0 0 ffffffff 00000001 00000000 00000000 09 1 00000000 0 00000000
sra_neg      0 8 0 1 80000000 00000004 00000000 00000000 0a 1 f8000000 0 00000000
srl_neg      0 8 0 0 80000000 00000004 00000000 00000000 0b 1 08000000 0 00000000
sll_mask     0 7 0 0 00000001 00000024 00000000 00000000 0c 1 00000010 0 00000000
bubble_a     0 0 0 0 00000000 00000000 00000000 00000000 00 0 00000000 0 00000000
rand_add     0 0 0 0 00000000 00000000 00000000 00000000 0d 1 00000000 0 00000000
rand_xor     0 5 0 0 00000000 00000000 00000000 00000000 0e 1 00000000 0 00000000
rand_nor     0 6 0 0 00000000 00000000 00000000 00000000 0f 1 00000000 0 00000000
rand_and     0 3 0 0 00000000 00000000 00000000 00000000 10 1 00000000 0 00000000
beq_taken    1 0 0 0 00000005 00000005 00001000 00000040 01 0 00000000 1 00001040
beq_not      1 0 0 0 00000005 00000006 00001000 00000040 01 0 00000000 0 00000000
bne_taken    1 0 1 0 00000005 00000006 00002000 fffffff0 01 0 00000000 1 00001ff0
blt_signed   1 0 2 1 ffffffff 00000001 00003000 00000008 01 0 00000000 1 00003008
blt_unsigned 1 0 2 0 ffffffff 00000001 00003000 00000008 01 0 00000000 0 00000000
bge_taken    1 0 3 1 00000003 fffffffe 00004000 00000010 01 0 00000000 1 00004010
jirl_link    1 0 4 0 00008000 00000000 00005000 00000100 01 1 00005004 1 00008100
bubble_b     0 0 0 0 00000000 00000000 00000000 00000000 00 0 00000000 0 00000000
bl_link      1 0 5 0 00000000 00000000 00006000 00000200 1f 1 00006004 1 00006200
bl_rd_zero   1 0 5 0 00000000 00000000 00007000 00000020 00 0 00000000 1 00007020
add_after    0 0 0 0 00000010 00000020 00000000 00000000 02 1 00000030 0 00000000

//--- exec_stage.f
+incdir+hdl
hdl/exec_pkg.sv
hdl/exec_op_if.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/exec_writeback.sv
hdl/exec_stage.sv
test/exec_stage_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = exec_stage_tb
FILELIST  = exec_stage.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
